//--- instr_decoder.f
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/instr_capture.sv
rtl/special_decoder.sv
rtl/main_decoder.sv
rtl/ctrl_output.sv
rtl/instr_decoder.sv
verif/instr_decoder_sva.sv
verif/instr_decoder_tb.sv

//--- Bender.yml
package:
  name: instr_decoder

sources:
  - rtl/isa_pkg.sv
  - rtl/ctrl_pkg.sv
  - rtl/instr_capture.sv
  - rtl/special_decoder.sv
  - rtl/main_decoder.sv
  - rtl/ctrl_output.sv
  - rtl/instr_decoder.sv
  - target: test
    files:
      - verif/instr_decoder_sva.sv
      - verif/instr_decoder_tb.sv

//--- verif/instr_decoder_tb.sv
`default_nettype none

module instr_decoder_tb;

    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int num_tests       = 6;
    localparam int cycles_per_test = 300;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       instr_valid;
    instr_t     instr;
    ctrl_word_t ctrl;
    logic       ctrl_valid;

    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    integer seed = 32'h23e5;
    instr_t pool [$];  // kept instructions for the stream test

    instr_decoder u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl        (ctrl),
        .ctrl_valid  (ctrl_valid)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // expected control word
    ////////////////////////////////////////////////////////////////////////////
    function automatic ctrl_word_t expected_ctrl(instr_t word);
        instr_fields_t f;
        ctrl_word_t    e;
        branch_e       br;
        logic          alu_r;
        logic          is_imm;
        logic          is_load;
        logic          is_store;
        f        = word;
        e        = ctrl_idle;
        br       = br_none;
        alu_r    = 1'b1;
        is_imm   = 1'b1;
        is_load  = (f.op == op_lw) || (f.op == op_lh) || (f.op == op_lhu)
                || (f.op == op_lb) || (f.op == op_lbu);
        is_store = (f.op == op_sw) || (f.op == op_sh) || (f.op == op_sb);
        if (f.op == op_special) begin
            case (f.funct)
                fn_add, fn_addu:  e.alu_op = alu_add;
                fn_sub, fn_subu:  e.alu_op = alu_sub;
                fn_and:           e.alu_op = alu_and;
                fn_or:            e.alu_op = alu_or;
                fn_xor:           e.alu_op = alu_xor;
                fn_nor:           e.alu_op = alu_nor;
                fn_slt:           e.alu_op = alu_slt;
                fn_sltu:          e.alu_op = alu_sltu;
                fn_sll, fn_sllv:  e.alu_op = alu_sll;
                fn_srl, fn_srlv:  e.alu_op = alu_srl;
                fn_sra, fn_srav:  e.alu_op = alu_sra;
                default:          alu_r = 1'b0;
            endcase
            if (alu_r) begin
                e.alu_a_shamt = (f.funct == fn_sll) || (f.funct == fn_srl)
                             || (f.funct == fn_sra);
                e.reg_dst     = dst_rd;
                e.wb_sel      = wb_alu;
                e.reg_write   = 1'b1;
            end
            case (f.funct)
                fn_jr:    e.pc_sel = pc_reg;
                fn_jalr: begin
                    e.pc_sel    = pc_reg;
                    e.reg_dst   = dst_rd;
                    e.wb_sel    = wb_link;
                    e.reg_write = 1'b1;
                end
                fn_mult:  e.md_op = md_mult;
                fn_multu: e.md_op = md_multu;
                fn_div:   e.md_op = md_div;
                fn_divu:  e.md_op = md_divu;
                fn_mthi:  e.hilo_op = hilo_mthi;
                fn_mtlo:  e.hilo_op = hilo_mtlo;
                fn_mfhi, fn_mflo: begin
                    e.hilo_op   = (f.funct == fn_mfhi) ? hilo_mfhi : hilo_mflo;
                    e.reg_dst   = dst_rd;
                    e.wb_sel    = wb_hilo;
                    e.reg_write = 1'b1;
                end
                default: ;
            endcase
            return e;
        end
        if (is_load || is_store) begin
            e.alu_b_imm = 1'b1;
            e.alu_op    = alu_add;
            e.ext_op    = ext_sign;
            e.mem_op    = is_load ? mem_load : mem_store;
            case (f.op)
                op_lh, op_sh: e.mem_size = sz_half;
                op_lhu:       e.mem_size = sz_half_u;
                op_lb, op_sb: e.mem_size = sz_byte;
                op_lbu:       e.mem_size = sz_byte_u;
                default:      e.mem_size = sz_word;
            endcase
            if (is_load) begin
                e.reg_write = 1'b1;
                e.wb_sel    = wb_mem;
                e.reg_dst   = dst_rt;
            end
            return e;
        end
        case (f.op)
            op_addi, op_addiu: e.alu_op = alu_add;
            op_slti:           e.alu_op = alu_slt;
            op_sltiu:          e.alu_op = alu_sltu;
            op_andi:           e.alu_op = alu_and;
            op_ori:            e.alu_op = alu_or;
            op_xori:           e.alu_op = alu_xor;
            op_lui:            e.alu_op = alu_add;
            default:           is_imm = 1'b0;
        endcase
        if (is_imm) begin
            e.alu_b_imm = 1'b1;
            e.reg_write = 1'b1;
            e.reg_dst   = dst_rt;
            if (f.op == op_andi || f.op == op_ori || f.op == op_xori) begin
                e.ext_op = ext_zero;
            end else if (f.op == op_lui) begin
                e.ext_op = ext_upper;
            end
        end
        case (f.op)
            op_beq:       br = br_eq;
            op_bne:       br = br_ne;
            op_blez:      br = br_lez;
            op_bgtz:      br = br_gtz;
            op_j, op_jal: br = br_jump;
            op_regimm: begin
                if (f.rt == rt_bltz) br = br_ltz;
                else if (f.rt == rt_bgez) br = br_gez;
            end
            default: ;
        endcase
        if (br != br_none) begin
            e.branch = br;
            e.pc_sel = pc_target;
        end
        if (f.op == op_jal) begin
            e.reg_write = 1'b1;
            e.reg_dst   = dst_ra;
            e.wb_sel    = wb_link;
        end
        if (f.op == op_cop0) begin
            if (f.funct == fn_eret) begin
                e.pc_sel = pc_epc;
            end else if (f.rs == rs_mfc0) begin
                e.reg_write = 1'b1;
                e.wb_sel    = wb_cp0;
            end else if (f.rs == rs_mtc0) begin
                e.wb_sel = wb_cp0;
            end
        end
        return e;
    endfunction

    function automatic instr_t r_word(funct_t fn);
        return {op_special, 5'd8, 5'd9, 5'd10, 5'd3, fn};
    endfunction

    function automatic instr_t i_word(opcode_t op, reg_addr_t rt);
        return {op, 5'd4, rt, 16'h8001};
    endfunction

    function automatic instr_t cop0_word(reg_addr_t rs, funct_t fn);
        return {op_cop0, rs, 5'd9, 5'd12, 5'd0, fn};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks and reporting
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_ctrl(input string what, input ctrl_word_t got,
                              input ctrl_word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: ctrl (%s) expected %h got %h",
                     $time, what, exp, got);
            errors++;
        end
    endtask

    task automatic check_valid(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: ctrl_valid (%s) expected %b got %b",
                     $time, what, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        tests_run++;
        if (errors != start_err) tests_failed++;
        $display("%-12s %s, %0d errors", name,
                 (errors == start_err) ? "ok" : "failed", errors - start_err);
    endtask

    // drives one instruction and checks its response two edges later
    task automatic apply_one(input instr_t word, input string what, input logic keep);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        @(posedge clk);
        instr_valid <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_valid(what, ctrl_valid, 1'b1);
        check_ctrl(what, ctrl, expected_ctrl(word));
        if (keep) pool.push_back(word);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_values();
        int start_err;
        start_err = errors;
        repeat (3) begin
            @(negedge clk);
            check_valid("after reset", ctrl_valid, 1'b0);
            check_ctrl("after reset", ctrl, ctrl_idle);
        end
        report_test("reset", start_err);
    endtask

    task automatic special_functions();
        int     start_err;
        instr_t w;
        start_err = errors;
        for (int fn = 0; fn < 64; fn++) begin  // every code including unknown ones
            w = r_word(funct_t'(fn));
            apply_one(w, $sformatf("funct %b", w[5:0]), expected_ctrl(w) != ctrl_idle);
        end
        report_test("special", start_err);
    endtask

    task automatic mem_and_imm_ops();
        int      start_err;
        opcode_t ops [16];
        start_err = errors;
        ops = '{op_lw, op_lh, op_lhu, op_lb, op_lbu, op_sw, op_sh, op_sb, op_addi,
                op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui};
        foreach (ops[n]) begin
            apply_one(i_word(ops[n], 5'd5), $sformatf("op %b", ops[n]), 1'b1);
        end
        report_test("mem_imm", start_err);
    endtask

    task automatic branch_ops();
        int      start_err;
        opcode_t ops [6];
        start_err = errors;
        ops = '{op_beq, op_bne, op_blez, op_bgtz, op_j, op_jal};
        foreach (ops[n]) begin
            apply_one(i_word(ops[n], 5'd5), $sformatf("op %b", ops[n]), 1'b1);
        end
        apply_one(i_word(op_regimm, rt_bltz), "bltz", 1'b1);
        apply_one(i_word(op_regimm, rt_bgez), "bgez", 1'b1);
        apply_one(i_word(op_regimm, 5'b00010), "regimm unused rt", 1'b0);
        report_test("branch", start_err);
    endtask

    task automatic cop0_and_unknown();
        int start_err;
        start_err = errors;
        apply_one(cop0_word(rs_mtc0, 6'd0), "mtc0", 1'b1);
        apply_one(cop0_word(rs_mfc0, 6'd0), "mfc0", 1'b1);
        apply_one(cop0_word(5'b10000, fn_eret), "eret", 1'b1);
        apply_one(cop0_word(rs_mfc0, fn_eret), "eret over mfc0", 1'b0);
        apply_one(cop0_word(rs_mtc0, fn_eret), "eret over mtc0", 1'b0);
        apply_one(cop0_word(5'b00010, 6'd0), "cop0 unused rs", 1'b0);
        apply_one(i_word(6'b111111, 5'd1), "unknown op 3f", 1'b0);
        apply_one(i_word(6'b010011, 5'd1), "unknown op 13", 1'b0);
        report_test("cop0", start_err);
    endtask

    task automatic back_to_back_stream();
        int         start_err;
        int         got;
        instr_t     word;
        ctrl_word_t exp_q [$];
        start_err = errors;
        got       = 0;
        fork
            begin
                for (int n = 0; n < 40; n++) begin
                    @(posedge clk);
                    word = pool[$unsigned($random(seed)) % pool.size()];
                    instr_valid <= 1'b1;
                    instr       <= word;
                    exp_q.push_back(expected_ctrl(word));
                end
                @(posedge clk);
                instr_valid <= 1'b0;
            end
            begin
                while (got < 40) begin
                    @(negedge clk);
                    if (ctrl_valid) begin
                        if (exp_q.size() == 0) begin
                            $display("ctrl_valid pulse at %0t with no instruction in flight",
                                     $time);
                            errors++;
                        end else begin
                            check_ctrl($sformatf("stream %0d", got), ctrl, exp_q.pop_front());
                        end
                        got++;
                    end
                end
            end
        join
        report_test("stream", start_err);
    endtask

    initial begin
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        reset_values();
        special_functions();
        mem_and_imm_ops();
        branch_ops();
        cop0_and_unknown();
        back_to_back_stream();
        if (u_dut.u_sva.fail_count != 0) begin
            $display("%0d bound assertions failed during the run",
                     u_dut.u_sva.fail_count);
            errors += u_dut.u_sva.fail_count;
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin  // watchdog
        #((num_tests * cycles_per_test + 4) * 10);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/instr_decoder_sva.sv
`default_nettype none

module instr_decoder_sva (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 instr_valid,
    input ctrl_pkg::ctrl_word_t ctrl,
    input logic                 ctrl_valid
);

    import ctrl_pkg::*;

    int fail_count = 0;

    a_valid_after_two: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid |-> ##2 ctrl_valid)
        else begin
            $error("ctrl_valid missing two cycles after instr_valid");
            fail_count++;
        end

    a_no_stray_valid: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl_valid |-> $past(instr_valid, 2))
        else begin
            $error("ctrl_valid without instr_valid two cycles before");
            fail_count++;
        end

    a_store_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl.mem_op == mem_store |-> !ctrl.reg_write)
        else begin
            $error("store with reg_write set");
            fail_count++;
        end

    a_ra_is_link: assert property (@(posedge clk) disable iff (!arst_n)
        (ctrl.reg_write && ctrl.reg_dst == dst_ra) |-> ctrl.wb_sel == wb_link)
        else begin
            $error("write to ra without link write-back");
            fail_count++;
        end

endmodule

bind instr_decoder instr_decoder_sva u_sva (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .ctrl        (ctrl),
    .ctrl_valid  (ctrl_valid)
);

`default_nettype wire

//--- rtl/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 instr_valid,
    input  isa_pkg::instr_t      instr,
    output ctrl_pkg::ctrl_word_t ctrl,
    output logic                 ctrl_valid
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    instr_fields_t fields;
    instr_class_e  cls;
    logic          fields_valid;
    ctrl_word_t    special_ctrl;
    ctrl_word_t    main_ctrl;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1 capture, decode in between, stage 2 output
    ////////////////////////////////////////////////////////////////////////////
    instr_capture u_capture (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .fields       (fields),
        .cls          (cls),
        .fields_valid (fields_valid)
    );

    special_decoder u_special_dec (
        .fields       (fields),
        .special_ctrl (special_ctrl)
    );

    main_decoder u_main_dec (
        .fields    (fields),
        .main_ctrl (main_ctrl)
    );

    ctrl_output u_output (
        .clk          (clk),
        .arst_n       (arst_n),
        .fields_valid (fields_valid),
        .cls          (cls),
        .special_ctrl (special_ctrl),
        .main_ctrl    (main_ctrl),
        .ctrl         (ctrl),
        .ctrl_valid   (ctrl_valid)
    );

endmodule

`default_nettype wire

//--- rtl/ctrl_output.sv
`default_nettype none

module ctrl_output (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  fields_valid,
    input  isa_pkg::instr_class_e cls,
    input  ctrl_pkg::ctrl_word_t  special_ctrl,
    input  ctrl_pkg::ctrl_word_t  main_ctrl,
    output ctrl_pkg::ctrl_word_t  ctrl,
    output logic                  ctrl_valid
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    ctrl_word_t sel_ctrl;

    // regimm and cop0 are decoded in main_decoder
    assign sel_ctrl = (cls == class_special) ? special_ctrl : main_ctrl;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl       <= ctrl_idle;
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= fields_valid;
            if (fields_valid) begin
                ctrl <= sel_ctrl;  // held between strobes
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/main_decoder.sv
`default_nettype none

module main_decoder (
    input  isa_pkg::instr_fields_t fields,
    output ctrl_pkg::ctrl_word_t   main_ctrl
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    // base + sign-extended offset address
    function automatic ctrl_word_t mem_word(mem_op_e op, mem_size_e size);
        ctrl_word_t w;
        w           = ctrl_idle;
        w.alu_b_imm = 1'b1;
        w.alu_op    = alu_add;
        w.ext_op    = ext_sign;
        w.mem_op    = op;
        w.mem_size  = size;
        if (op == mem_load) begin
            w.reg_write = 1'b1;
            w.wb_sel    = wb_mem;
            w.reg_dst   = dst_rt;
        end
        return w;
    endfunction

    function automatic ctrl_word_t imm_word(alu_op_e op, ext_op_e ext);
        ctrl_word_t w;
        w           = ctrl_idle;
        w.alu_b_imm = 1'b1;
        w.alu_op    = op;
        w.ext_op    = ext;
        w.reg_dst   = dst_rt;
        w.reg_write = 1'b1;
        return w;
    endfunction

    function automatic ctrl_word_t branch_word(branch_e br);
        ctrl_word_t w;
        w        = ctrl_idle;
        w.pc_sel = pc_target;
        w.branch = br;
        return w;
    endfunction

    always_comb begin
        main_ctrl = ctrl_idle;  // special and unknown opcodes
        case (fields.op)
            op_lw:    main_ctrl = mem_word(mem_load, sz_word);
            op_lh:    main_ctrl = mem_word(mem_load, sz_half);
            op_lhu:   main_ctrl = mem_word(mem_load, sz_half_u);
            op_lb:    main_ctrl = mem_word(mem_load, sz_byte);
            op_lbu:   main_ctrl = mem_word(mem_load, sz_byte_u);
            op_sw:    main_ctrl = mem_word(mem_store, sz_word);
            op_sh:    main_ctrl = mem_word(mem_store, sz_half);
            op_sb:    main_ctrl = mem_word(mem_store, sz_byte);
            op_addi:  main_ctrl = imm_word(alu_add, ext_sign);
            op_addiu: main_ctrl = imm_word(alu_add, ext_sign);
            op_slti:  main_ctrl = imm_word(alu_slt, ext_sign);
            op_sltiu: main_ctrl = imm_word(alu_sltu, ext_sign);
            op_andi:  main_ctrl = imm_word(alu_and, ext_zero);
            op_ori:   main_ctrl = imm_word(alu_or, ext_zero);
            op_xori:  main_ctrl = imm_word(alu_xor, ext_zero);
            op_lui:   main_ctrl = imm_word(alu_add, ext_upper);  // zero + imm << 16
            op_beq:   main_ctrl = branch_word(br_eq);
            op_bne:   main_ctrl = branch_word(br_ne);
            op_blez:  main_ctrl = branch_word(br_lez);
            op_bgtz:  main_ctrl = branch_word(br_gtz);
            op_j:     main_ctrl = branch_word(br_jump);
            op_jal: begin
                main_ctrl           = branch_word(br_jump);
                main_ctrl.reg_write = 1'b1;
                main_ctrl.reg_dst   = dst_ra;
                main_ctrl.wb_sel    = wb_link;
            end
            op_regimm: begin
                if (fields.rt == rt_bltz) begin
                    main_ctrl = branch_word(br_ltz);
                end else if (fields.rt == rt_bgez) begin
                    main_ctrl = branch_word(br_gez);
                end
            end
            op_cop0: begin
                if (fields.funct == fn_eret) begin
                    main_ctrl.pc_sel = pc_epc;  // eret wins over rs
                end else if (fields.rs == rs_mfc0) begin
                    main_ctrl.reg_write = 1'b1;
                    main_ctrl.wb_sel    = wb_cp0;
                end else if (fields.rs == rs_mtc0) begin
                    main_ctrl.wb_sel = wb_cp0;  // cp0 write without a gpr write
                end
            end
            default: main_ctrl = ctrl_idle;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/special_decoder.sv
`default_nettype none

module special_decoder (
    input  isa_pkg::instr_fields_t fields,
    output ctrl_pkg::ctrl_word_t   special_ctrl
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    // register-register alu op, result into rd
    function automatic ctrl_word_t r_alu(alu_op_e op, logic use_shamt);
        ctrl_word_t w;
        w             = ctrl_idle;
        w.alu_op      = op;
        w.alu_a_shamt = use_shamt;
        w.reg_dst     = dst_rd;
        w.wb_sel      = wb_alu;
        w.reg_write   = 1'b1;
        return w;
    endfunction

    always_comb begin
        special_ctrl = ctrl_idle;  // unknown funct stays idle
        case (fields.funct)
            fn_add, fn_addu: special_ctrl = r_alu(alu_add, 1'b0);
            fn_sub, fn_subu: special_ctrl = r_alu(alu_sub, 1'b0);
            fn_and:          special_ctrl = r_alu(alu_and, 1'b0);
            fn_or:           special_ctrl = r_alu(alu_or, 1'b0);
            fn_xor:          special_ctrl = r_alu(alu_xor, 1'b0);
            fn_nor:          special_ctrl = r_alu(alu_nor, 1'b0);
            fn_slt:          special_ctrl = r_alu(alu_slt, 1'b0);
            fn_sltu:         special_ctrl = r_alu(alu_sltu, 1'b0);
            fn_sll:          special_ctrl = r_alu(alu_sll, 1'b1);
            fn_srl:          special_ctrl = r_alu(alu_srl, 1'b1);
            fn_sra:          special_ctrl = r_alu(alu_sra, 1'b1);
            fn_sllv:         special_ctrl = r_alu(alu_sll, 1'b0);
            fn_srlv:         special_ctrl = r_alu(alu_srl, 1'b0);
            fn_srav:         special_ctrl = r_alu(alu_sra, 1'b0);
            fn_jr: begin
                special_ctrl.pc_sel = pc_reg;
            end
            fn_jalr: begin
                special_ctrl.pc_sel    = pc_reg;
                special_ctrl.reg_dst   = dst_rd;
                special_ctrl.wb_sel    = wb_link;
                special_ctrl.reg_write = 1'b1;
            end
            // multiply and divide write hi/lo, not the register file
            fn_mult:  special_ctrl.md_op = md_mult;
            fn_multu: special_ctrl.md_op = md_multu;
            fn_div:   special_ctrl.md_op = md_div;
            fn_divu:  special_ctrl.md_op = md_divu;
            fn_mfhi: begin
                special_ctrl.hilo_op   = hilo_mfhi;
                special_ctrl.reg_dst   = dst_rd;
                special_ctrl.wb_sel    = wb_hilo;
                special_ctrl.reg_write = 1'b1;
            end
            fn_mflo: begin
                special_ctrl.hilo_op   = hilo_mflo;
                special_ctrl.reg_dst   = dst_rd;
                special_ctrl.wb_sel    = wb_hilo;
                special_ctrl.reg_write = 1'b1;
            end
            fn_mthi: special_ctrl.hilo_op = hilo_mthi;
            fn_mtlo: special_ctrl.hilo_op = hilo_mtlo;
            default: special_ctrl = ctrl_idle;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/instr_capture.sv
`default_nettype none

module instr_capture (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   instr_valid,
    input  isa_pkg::instr_t        instr,
    output isa_pkg::instr_fields_t fields,
    output isa_pkg::instr_class_e  cls,
    output logic                   fields_valid
);

    import isa_pkg::*;

    instr_class_e cls_next;

    always_comb begin
        case (instr[31:26])
            op_special: cls_next = class_special;
            op_regimm:  cls_next = class_regimm;
            op_cop0:    cls_next = class_cop0;
            default:    cls_next = class_main;
        endcase
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            fields <= instr;
            cls    <= cls_next;  // registered select for the output mux
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fields_valid <= 1'b0;
        end else begin
            fields_valid <= instr_valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [3:0] {
        alu_and  = 4'b0000,
        alu_or   = 4'b0001,
        alu_add  = 4'b0010,
        alu_sub  = 4'b0011,
        alu_xor  = 4'b0100,
        alu_nor  = 4'b0101,
        alu_sll  = 4'b0110,
        alu_srl  = 4'b0111,
        alu_sra  = 4'b1000,
        alu_slt  = 4'b1001,
        alu_sltu = 4'b1010
    } alu_op_e;

    typedef enum logic [1:0] {
        dst_rt,
        dst_rd,
        dst_ra    // r31 for jal
    } reg_dst_e;

    typedef enum logic [2:0] {
        wb_alu,
        wb_mem,
        wb_link,  // return address
        wb_hilo,
        wb_cp0
    } wb_sel_e;

    typedef enum logic [1:0] {
        ext_sign,
        ext_zero,
        ext_upper  // imm16 into the top half
    } ext_op_e;

    typedef enum logic [1:0] {
        pc_next,
        pc_reg,
        pc_target,
        pc_epc
    } pc_sel_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lez,
        br_gtz,
        br_ltz,
        br_gez,
        br_jump
    } branch_e;

    typedef enum logic [2:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_e;

    typedef enum logic [2:0] {
        sz_word,
        sz_half,
        sz_half_u,
        sz_byte,
        sz_byte_u
    } mem_size_e;

    typedef enum logic [2:0] {
        md_none,
        md_mult,
        md_multu,
        md_div,
        md_divu
    } md_op_e;

    typedef enum logic [2:0] {
        hilo_none,
        hilo_mthi,
        hilo_mtlo,
        hilo_mfhi,
        hilo_mflo
    } hilo_op_e;

    typedef struct packed {
        alu_op_e   alu_op;
        reg_dst_e  reg_dst;
        wb_sel_e   wb_sel;
        ext_op_e   ext_op;
        pc_sel_e   pc_sel;
        branch_e   branch;
        mem_op_e   mem_op;
        mem_size_e mem_size;
        md_op_e    md_op;  // anything but none starts the unit
        hilo_op_e  hilo_op;
        logic      alu_a_shamt;
        logic      alu_b_imm;
        logic      reg_write;
    } ctrl_word_t;

    localparam ctrl_word_t ctrl_idle = '{
        alu_op:      alu_and,
        reg_dst:     dst_rt,
        wb_sel:      wb_alu,
        ext_op:      ext_sign,
        pc_sel:      pc_next,
        branch:      br_none,
        mem_op:      mem_none,
        mem_size:    sz_word,
        md_op:       md_none,
        hilo_op:     hilo_none,
        alu_a_shamt: 1'b0,
        alu_b_imm:   1'b0,
        reg_write:   1'b0
    };

endpackage

`default_nettype wire

//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  reg_addr_t;

    typedef struct packed {
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_t    funct;
    } instr_fields_t;

    typedef enum logic [1:0] {
        class_special,
        class_regimm,
        class_cop0,
        class_main
    } instr_class_e;

    ////////////////////////////////////////////////////////////////////////////
    // primary opcodes
    ////////////////////////////////////////////////////////////////////////////
    localparam opcode_t op_special = 6'b000000;
    localparam opcode_t op_regimm  = 6'b000001;
    localparam opcode_t op_j       = 6'b000010;
    localparam opcode_t op_jal     = 6'b000011;
    localparam opcode_t op_beq     = 6'b000100;
    localparam opcode_t op_bne     = 6'b000101;
    localparam opcode_t op_blez    = 6'b000110;
    localparam opcode_t op_bgtz    = 6'b000111;
    localparam opcode_t op_addi    = 6'b001000;
    localparam opcode_t op_addiu   = 6'b001001;
    localparam opcode_t op_slti    = 6'b001010;
    localparam opcode_t op_sltiu   = 6'b001011;
    localparam opcode_t op_andi    = 6'b001100;
    localparam opcode_t op_ori     = 6'b001101;
    localparam opcode_t op_xori    = 6'b001110;
    localparam opcode_t op_lui     = 6'b001111;
    localparam opcode_t op_cop0    = 6'b010000;
    localparam opcode_t op_lb      = 6'b100000;
    localparam opcode_t op_lh      = 6'b100001;
    localparam opcode_t op_lw      = 6'b100011;
    localparam opcode_t op_lbu     = 6'b100100;
    localparam opcode_t op_lhu     = 6'b100101;
    localparam opcode_t op_sb      = 6'b101000;
    localparam opcode_t op_sh      = 6'b101001;
    localparam opcode_t op_sw      = 6'b101011;

    ////////////////////////////////////////////////////////////////////////////
    // function codes of the special opcode
    ////////////////////////////////////////////////////////////////////////////
    localparam funct_t fn_sll   = 6'b000000;  // also nop
    localparam funct_t fn_srl   = 6'b000010;
    localparam funct_t fn_sra   = 6'b000011;
    localparam funct_t fn_sllv  = 6'b000100;
    localparam funct_t fn_srlv  = 6'b000110;
    localparam funct_t fn_srav  = 6'b000111;
    localparam funct_t fn_jr    = 6'b001000;
    localparam funct_t fn_jalr  = 6'b001001;
    localparam funct_t fn_mfhi  = 6'b010000;
    localparam funct_t fn_mthi  = 6'b010001;
    localparam funct_t fn_mflo  = 6'b010010;
    localparam funct_t fn_mtlo  = 6'b010011;
    localparam funct_t fn_mult  = 6'b011000;
    localparam funct_t fn_multu = 6'b011001;
    localparam funct_t fn_div   = 6'b011010;
    localparam funct_t fn_divu  = 6'b011011;
    localparam funct_t fn_add   = 6'b100000;
    localparam funct_t fn_addu  = 6'b100001;
    localparam funct_t fn_sub   = 6'b100010;
    localparam funct_t fn_subu  = 6'b100011;
    localparam funct_t fn_and   = 6'b100100;
    localparam funct_t fn_or    = 6'b100101;
    localparam funct_t fn_xor   = 6'b100110;
    localparam funct_t fn_nor   = 6'b100111;
    localparam funct_t fn_slt   = 6'b101010;
    localparam funct_t fn_sltu  = 6'b101011;

    localparam reg_addr_t rt_bltz = 5'b00000;  // regimm, selected by rt
    localparam reg_addr_t rt_bgez = 5'b00001;
    localparam reg_addr_t rs_mfc0 = 5'b00000;  // cop0, selected by rs
    localparam reg_addr_t rs_mtc0 = 5'b00100;
    localparam funct_t    fn_eret = 6'b011000;

endpackage

`default_nettype wire
